/* list.f */
source/vctrl_pkg.sv
source/vctrl_decoder.sv
source/vctrl_csr_exec.sv
source/vctrl_issue.sv
source/vctrl_top.sv
tb/tb_clock_gen.sv
tb/tb_vctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_vctrl -Mdir obj_dir
./obj_dir/Vtb_vctrl | tee sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi

/* source/vctrl_csr_exec.sv */
// Vector CSR state and configuration execute
// Holds vstart, vl and vtype, runs vsetvl(i) and the CSR read/modify/write forms
`default_nettype none

module vctrl_csr_exec #(
  parameter int unsigned VLEN = 128
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         exec_fire_i,
  input  vctrl_pkg::op_kind_e          exec_kind_i,
  input  logic [31:0]                  exec_instr_i,
  input  logic [vctrl_pkg::ELEN-1:0]   exec_rs1_i,
  input  logic [vctrl_pkg::ELEN-1:0]   exec_rs2_i,
  output logic [vctrl_pkg::ELEN-1:0]   exec_data_o,
  output logic [vctrl_pkg::VL_W-1:0]   vl_o,
  output vctrl_pkg::vtype_t            vtype_o,
  output logic [vctrl_pkg::VL_W-1:0]   vstart_o,
  output logic                         vill_o
);

  localparam int unsigned VL_W = vctrl_pkg::VL_W;
  localparam int unsigned ELEN = vctrl_pkg::ELEN;
  localparam logic [VL_W-1:0] VLENB = VL_W'(VLEN / 8);
  localparam vctrl_pkg::vtype_t VTYPE_ILL = '{vill: 1'b1, default: '0};

  vctrl_pkg::instr_u instr;
  vctrl_pkg::vtype_t cfg_vtype;
  logic              cfg_ok;
  logic [VL_W-1:0]   sew_max;
  logic [VL_W-1:0]   vlmax;
  logic [VL_W-1:0]   cfg_vl;
  logic [ELEN-1:0]   csr_old;
  logic [VL_W-1:0]   csr_wdata;

  vctrl_pkg::vtype_t vtype_q;
  vctrl_pkg::vtype_t vtype_d;
  logic [VL_W-1:0]   vl_q;
  logic [VL_W-1:0]   vl_d;
  logic [VL_W-1:0]   vstart_q;
  logic [VL_W-1:0]   vstart_d;

  assign instr = vctrl_pkg::instr_u'(exec_instr_i);

  //////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////

  always_comb begin : cfg_calc
    // vsetvl has bit 31 set and takes vtype from rs2
    if (instr.cfg.b31) begin
      cfg_vtype = vctrl_pkg::vtype_t'({1'b0, exec_rs2_i[7:0]});
    end else begin
      cfg_vtype = vctrl_pkg::vtype_t'({1'b0, instr.cfg.zimm[7:0]});
    end
    cfg_ok = (cfg_vtype.vsew < vctrl_pkg::vsew_64) &&
             !(cfg_vtype.vlmul inside {vctrl_pkg::lmul_res, vctrl_pkg::lmul_f8});

    sew_max = VLENB >> cfg_vtype.vsew;
    case (cfg_vtype.vlmul)
      vctrl_pkg::lmul_1:  vlmax = sew_max;
      vctrl_pkg::lmul_2:  vlmax = sew_max << 1;
      vctrl_pkg::lmul_4:  vlmax = sew_max << 2;
      vctrl_pkg::lmul_8:  vlmax = sew_max << 3;
      vctrl_pkg::lmul_f4: vlmax = sew_max >> 2;
      vctrl_pkg::lmul_f2: vlmax = sew_max >> 1;
      default:            vlmax = '0;
    endcase

    // rs1 = x0 with rd != x0 requests vlmax
    if (!cfg_ok) begin
      cfg_vl = '0;
    end else if (instr.cfg.rs1 == 5'd0 && instr.cfg.rd != 5'd0) begin
      cfg_vl = vlmax;
    end else if (exec_rs1_i < ELEN'(vlmax)) begin
      cfg_vl = VL_W'(exec_rs1_i);
    end else begin
      cfg_vl = vlmax;
    end
  end

  //////////////////////////////////////////////////
  // CSR access
  //////////////////////////////////////////////////

  always_comb begin : csr_calc
    case (instr.csr.csr)
      vctrl_pkg::csr_vstart: csr_old = ELEN'(vstart_q);
      vctrl_pkg::csr_vl:     csr_old = ELEN'(vl_q);
      vctrl_pkg::csr_vtype:  csr_old = {vtype_q.vill, {(ELEN-9){1'b0}}, vtype_q[7:0]};
      vctrl_pkg::csr_vlenb:  csr_old = ELEN'(VLENB);
      default:               csr_old = '0;
    endcase

    case (vctrl_pkg::csr_fn_e'(instr.csr.funct3[1:0]))
      vctrl_pkg::csr_rw: csr_wdata = VL_W'(exec_rs1_i);
      vctrl_pkg::csr_rs: csr_wdata = vstart_q | VL_W'(exec_rs1_i);
      vctrl_pkg::csr_rc: csr_wdata = vstart_q & ~VL_W'(exec_rs1_i);
      default:           csr_wdata = vstart_q;
    endcase
  end

  always_comb begin : next_state
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    vstart_d = vstart_q;
    if (exec_fire_i) begin
      case (exec_kind_i)
        vctrl_pkg::op_cfg: begin
          vl_d    = cfg_vl;
          vtype_d = cfg_ok ? cfg_vtype : VTYPE_ILL;
        end
        vctrl_pkg::op_csr: begin
          if (instr.csr.csr == vctrl_pkg::csr_vstart) begin
            vstart_d = csr_wdata;
          end
        end
        // Every dispatched vector operation restarts at element 0
        default: vstart_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vl_q     <= '0;
      vtype_q  <= VTYPE_ILL;
      vstart_q <= '0;
    end else begin
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
      vstart_q <= vstart_d;
    end
  end

  assign exec_data_o = (exec_kind_i == vctrl_pkg::op_cfg) ? ELEN'(cfg_vl) : csr_old;
  assign vl_o        = vl_q;
  assign vtype_o     = vtype_q;
  assign vstart_o    = vstart_q;
  assign vill_o      = vtype_q.vill;

  vl_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vl_q <= VL_W'(VLEN));

endmodule

`default_nettype wire

/* source/vctrl_decoder.sv */
// Vector controller decode stage
// Classifies an issued word, answers accept or reject and registers the operation
`default_nettype none

module vctrl_decoder (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         issue_valid_i,
  input  logic [31:0]                  issue_instr_i,
  input  logic [vctrl_pkg::ELEN-1:0]   issue_rs1_i,
  input  logic [vctrl_pkg::ELEN-1:0]   issue_rs2_i,
  input  logic [vctrl_pkg::ID_W-1:0]   issue_id_i,
  output logic                         issue_ready_o,
  output logic                         issue_accept_o,
  input  logic                         vill_i,
  input  logic                         dec_ready_i,
  output logic                         dec_valid_o,
  output vctrl_pkg::op_kind_e          dec_kind_o,
  output logic [31:0]                  dec_instr_o,
  output logic [vctrl_pkg::ELEN-1:0]   dec_rs1_o,
  output logic [vctrl_pkg::ELEN-1:0]   dec_rs2_o,
  output logic [vctrl_pkg::ID_W-1:0]   dec_id_o
);

  vctrl_pkg::instr_u   instr;
  vctrl_pkg::op_kind_e kind;
  logic                csr_known;
  logic                csr_write;
  logic                accept;
  logic                load;

  assign instr = vctrl_pkg::instr_u'(issue_instr_i);

  //////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////

  always_comb begin : classify
    csr_known = instr.csr.csr inside {vctrl_pkg::csr_vstart, vctrl_pkg::csr_vl,
                                      vctrl_pkg::csr_vtype, vctrl_pkg::csr_vlenb};
    // csrrs and csrrc with x0 only read
    csr_write = (instr.csr.funct3[1:0] == vctrl_pkg::csr_rw) || (instr.csr.rs1 != 5'd0);
    kind      = vctrl_pkg::op_vec;
    accept    = 1'b0;

    if (instr.cfg.opcode == vctrl_pkg::opc_op_v) begin
      if (instr.cfg.funct3 == vctrl_pkg::funct3_opcfg) begin
        kind   = vctrl_pkg::op_cfg;
        accept = 1'b1;
      end else begin
        // No arithmetic on an illegal vtype
        kind   = vctrl_pkg::op_vec;
        accept = !vill_i;
      end
    end else if (instr.csr.opcode == vctrl_pkg::opc_system &&
                 instr.csr.funct3 inside {3'd1, 3'd2, 3'd3}) begin
      kind   = vctrl_pkg::op_csr;
      // Only vstart is writable
      accept = csr_known && (!csr_write || instr.csr.csr == vctrl_pkg::csr_vstart);
    end
  end

  assign issue_accept_o = accept;
  assign issue_ready_o  = !dec_valid_o || dec_ready_i;
  assign load           = issue_valid_i && issue_ready_o && accept;

  //////////////////////////////////////////////////
  // Decode register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else if (load) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      dec_kind_o  <= kind;
      dec_instr_o <= issue_instr_i;
      dec_rs1_o   <= issue_rs1_i;
      dec_rs2_o   <= issue_rs2_i;
      dec_id_o    <= issue_id_i;
    end
  end

  // A waiting operation stays put until the issue stage takes it
  dec_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_instr_o));

endmodule

`default_nettype wire

/* source/vctrl_issue.sv */
// Vector controller issue and write-back stage
// Output register that routes vector work to the vector unit and scalar
// results back to the core, both under valid/ready back-pressure
`default_nettype none

module vctrl_issue (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         dec_valid_i,
  input  vctrl_pkg::op_kind_e          dec_kind_i,
  input  logic [31:0]                  dec_instr_i,
  input  logic [vctrl_pkg::ID_W-1:0]   dec_id_i,
  output logic                         dec_ready_o,
  output logic                         exec_fire_o,
  input  logic [vctrl_pkg::ELEN-1:0]   exec_data_i,
  input  logic [vctrl_pkg::VL_W-1:0]   vl_i,
  input  vctrl_pkg::vtype_t            vtype_i,
  input  logic [vctrl_pkg::VL_W-1:0]   vstart_i,
  output logic                         vec_valid_o,
  output logic [31:0]                  vec_instr_o,
  output logic [vctrl_pkg::VL_W-1:0]   vec_vl_o,
  output vctrl_pkg::vtype_t            vec_vtype_o,
  output logic [vctrl_pkg::VL_W-1:0]   vec_vstart_o,
  input  logic                         vec_ready_i,
  output logic                         result_valid_o,
  output logic [vctrl_pkg::ID_W-1:0]   result_id_o,
  output logic [4:0]                   result_rd_o,
  output logic [vctrl_pkg::ELEN-1:0]   result_data_o,
  input  logic                         result_ready_i
);

  logic                         out_valid_q;
  logic                         out_vec_q;
  logic                         out_done;
  vctrl_pkg::instr_u            instr_q;
  logic [vctrl_pkg::ID_W-1:0]   id_q;
  logic [vctrl_pkg::ELEN-1:0]   data_q;
  logic [vctrl_pkg::VL_W-1:0]   vl_q;
  vctrl_pkg::vtype_t            vtype_q;
  logic [vctrl_pkg::VL_W-1:0]   vstart_q;

  //////////////////////////////////////////////////
  // Flow control
  //////////////////////////////////////////////////

  assign vec_valid_o    = out_valid_q && out_vec_q;
  assign result_valid_o = out_valid_q && !out_vec_q;
  assign out_done       = (vec_valid_o && vec_ready_i) || (result_valid_o && result_ready_i);

  // Load when empty or when the held operation leaves this cycle
  assign dec_ready_o = !out_valid_q || out_done;
  assign exec_fire_o = dec_valid_i && dec_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      out_vec_q   <= 1'b0;
    end else if (exec_fire_o) begin
      out_valid_q <= 1'b1;
      out_vec_q   <= (dec_kind_i == vctrl_pkg::op_vec);
    end else if (out_done) begin
      out_valid_q <= 1'b0;
    end
  end

  // CSR values here are from before the update on this same edge
  always_ff @(posedge clk_i) begin
    if (exec_fire_o) begin
      instr_q  <= vctrl_pkg::instr_u'(dec_instr_i);
      id_q     <= dec_id_i;
      data_q   <= exec_data_i;
      vl_q     <= vl_i;
      vtype_q  <= vtype_i;
      vstart_q <= vstart_i;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign vec_instr_o  = instr_q;
  assign vec_vl_o     = vl_q;
  assign vec_vtype_o  = vtype_q;
  assign vec_vstart_o = vstart_q;

  // rd sits in the same place in both views
  assign result_id_o   = id_q;
  assign result_rd_o   = instr_q.csr.rd;
  assign result_data_o = data_q;

  // Vector unit sees the same operation until it takes it
  vec_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vec_valid_o && !vec_ready_i |=>
      vec_valid_o && $stable(vec_instr_o) && $stable(vec_vl_o) &&
      $stable(vec_vtype_o) && $stable(vec_vstart_o));

  // Core sees the same write-back until it takes it
  result_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o && !result_ready_i |=>
      result_valid_o && $stable(result_data_o) && $stable(result_id_o) &&
      $stable(result_rd_o));

endmodule

`default_nettype wire

/* source/vctrl_pkg.sv */
// Vector controller shared definitions
// Opcodes, CSR addresses, vtype layout and the two views of an instruction word
`default_nettype none

package vctrl_pkg;

  // Datapath widths
  localparam int unsigned ELEN = 32;
  localparam int unsigned ID_W = 4;
  localparam int unsigned VL_W = 16;

  //////////////////////////////////////////////////
  // Instruction and CSR encodings
  //////////////////////////////////////////////////

  localparam logic [6:0] opc_op_v     = 7'b1010111;
  localparam logic [6:0] opc_system   = 7'b1110011;
  localparam logic [2:0] funct3_opcfg = 3'd7;

  localparam logic [11:0] csr_vstart = 12'h008;
  localparam logic [11:0] csr_vl     = 12'hC20;
  localparam logic [11:0] csr_vtype  = 12'hC21;
  localparam logic [11:0] csr_vlenb  = 12'hC22;

  // Element width codes
  localparam logic [2:0] vsew_8  = 3'd0;
  localparam logic [2:0] vsew_16 = 3'd1;
  localparam logic [2:0] vsew_32 = 3'd2;
  localparam logic [2:0] vsew_64 = 3'd3;

  // Register group multiplier codes, 4 is reserved
  localparam logic [2:0] lmul_1   = 3'd0;
  localparam logic [2:0] lmul_2   = 3'd1;
  localparam logic [2:0] lmul_4   = 3'd2;
  localparam logic [2:0] lmul_8   = 3'd3;
  localparam logic [2:0] lmul_res = 3'd4;
  localparam logic [2:0] lmul_f8  = 3'd5;
  localparam logic [2:0] lmul_f4  = 3'd6;
  localparam logic [2:0] lmul_f2  = 3'd7;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Low eight bits follow the vtype CSR layout
  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  // vsetvli and vsetvl
  typedef struct packed {
    logic       b31;
    logic       b30;
    logic [9:0] zimm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } cfg_fmt_t;

  // Zicsr register forms
  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_fmt_t;

  typedef union packed {
    cfg_fmt_t cfg;
    csr_fmt_t csr;
  } instr_u;

  typedef enum logic [1:0] {
    op_cfg,
    op_csr,
    op_vec
  } op_kind_e;

  // Matches funct3[1:0] of csrrw, csrrs and csrrc
  typedef enum logic [1:0] {
    csr_rw = 2'd1,
    csr_rs = 2'd2,
    csr_rc = 2'd3
  } csr_fn_e;

endpackage

`default_nettype wire

/* source/vctrl_top.sv */
// Vector extension controller
// Decode, CSR execute and issue/write-back stages between the core and a vector unit
`default_nettype none

module vctrl_top #(
  parameter int unsigned VLEN = 128
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Issue from the core
  input  logic                         issue_valid_i,
  output logic                         issue_ready_o,
  input  logic [31:0]                  issue_instr_i,
  input  logic [vctrl_pkg::ELEN-1:0]   issue_rs1_i,
  input  logic [vctrl_pkg::ELEN-1:0]   issue_rs2_i,
  input  logic [vctrl_pkg::ID_W-1:0]   issue_id_i,
  output logic                         issue_accept_o,
  // Vector unit
  output logic                         vec_valid_o,
  input  logic                         vec_ready_i,
  output logic [31:0]                  vec_instr_o,
  output logic [vctrl_pkg::VL_W-1:0]   vec_vl_o,
  output vctrl_pkg::vtype_t            vec_vtype_o,
  output logic [vctrl_pkg::VL_W-1:0]   vec_vstart_o,
  // Write-back to the core
  output logic                         result_valid_o,
  input  logic                         result_ready_i,
  output logic [vctrl_pkg::ID_W-1:0]   result_id_o,
  output logic [4:0]                   result_rd_o,
  output logic [vctrl_pkg::ELEN-1:0]   result_data_o
);

  logic                         vill;
  logic                         dec_valid;
  logic                         dec_ready;
  vctrl_pkg::op_kind_e          dec_kind;
  logic [31:0]                  dec_instr;
  logic [vctrl_pkg::ELEN-1:0]   dec_rs1;
  logic [vctrl_pkg::ELEN-1:0]   dec_rs2;
  logic [vctrl_pkg::ID_W-1:0]   dec_id;
  logic                         exec_fire;
  logic [vctrl_pkg::ELEN-1:0]   exec_data;
  logic [vctrl_pkg::VL_W-1:0]   cur_vl;
  vctrl_pkg::vtype_t            cur_vtype;
  logic [vctrl_pkg::VL_W-1:0]   cur_vstart;

  vctrl_decoder vctrl_decoder_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (issue_valid_i),
    .issue_instr_i  (issue_instr_i),
    .issue_rs1_i    (issue_rs1_i),
    .issue_rs2_i    (issue_rs2_i),
    .issue_id_i     (issue_id_i),
    .issue_ready_o  (issue_ready_o),
    .issue_accept_o (issue_accept_o),
    .vill_i         (vill),
    .dec_ready_i    (dec_ready),
    .dec_valid_o    (dec_valid),
    .dec_kind_o     (dec_kind),
    .dec_instr_o    (dec_instr),
    .dec_rs1_o      (dec_rs1),
    .dec_rs2_o      (dec_rs2),
    .dec_id_o       (dec_id)
  );

  vctrl_csr_exec #(
    .VLEN (VLEN)
  ) vctrl_csr_exec_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .exec_fire_i  (exec_fire),
    .exec_kind_i  (dec_kind),
    .exec_instr_i (dec_instr),
    .exec_rs1_i   (dec_rs1),
    .exec_rs2_i   (dec_rs2),
    .exec_data_o  (exec_data),
    .vl_o         (cur_vl),
    .vtype_o      (cur_vtype),
    .vstart_o     (cur_vstart),
    .vill_o       (vill)
  );

  vctrl_issue vctrl_issue_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dec_valid_i    (dec_valid),
    .dec_kind_i     (dec_kind),
    .dec_instr_i    (dec_instr),
    .dec_id_i       (dec_id),
    .dec_ready_o    (dec_ready),
    .exec_fire_o    (exec_fire),
    .exec_data_i    (exec_data),
    .vl_i           (cur_vl),
    .vtype_i        (cur_vtype),
    .vstart_i       (cur_vstart),
    .vec_valid_o    (vec_valid_o),
    .vec_instr_o    (vec_instr_o),
    .vec_vl_o       (vec_vl_o),
    .vec_vtype_o    (vec_vtype_o),
    .vec_vstart_o   (vec_vstart_o),
    .vec_ready_i    (vec_ready_i),
    .result_valid_o (result_valid_o),
    .result_id_o    (result_id_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Clock and reset source for the testbench
// Free-running clock and an active-low reset held for a set number of cycles
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Release on a rising edge so the first stimulus edge sees a clean reset
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_vctrl.sv */
// Testbench for the vector extension controller
// Table-driven issue sequence checked against a model of vl, vtype and vstart
`default_nettype none

module tb_vctrl;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned VLEN       = 128;
  localparam int unsigned VLENB      = VLEN / 8;
  localparam int unsigned NUM_ROWS   = 25;
  localparam int unsigned CLK_PERIOD = 100;
  localparam int unsigned MAX_CYCLES = NUM_ROWS * 20 + 10;

  // vadd.vv vd, vs2, vs1 with vm set
  localparam logic [31:0] VADD_A = {6'd0, 1'b1, 5'd2, 5'd3, 3'd0, 5'd1, 7'h57};
  localparam logic [31:0] VADD_B = {6'd0, 1'b1, 5'd5, 5'd6, 3'd0, 5'd4, 7'h57};

  localparam logic [11:0] CSR_VSTART = 12'h008;
  localparam logic [11:0] CSR_VL     = 12'hC20;
  localparam logic [11:0] CSR_VTYPE  = 12'hC21;
  localparam logic [11:0] CSR_VLENB  = 12'hC22;

  typedef struct {
    string       name;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [3:0]  id;
    logic        accept;
    logic        to_vec;
    logic [31:0] data;
    logic        stall;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        issue_valid_i;
  logic        issue_ready_o;
  logic [31:0] issue_instr_i;
  logic [31:0] issue_rs1_i;
  logic [31:0] issue_rs2_i;
  logic [3:0]  issue_id_i;
  logic        issue_accept_o;
  logic        vec_valid_o;
  logic        vec_ready_i;
  logic [31:0] vec_instr_o;
  logic [15:0] vec_vl_o;
  logic [8:0]  vec_vtype_o;
  logic [15:0] vec_vstart_o;
  logic        result_valid_o;
  logic        result_ready_i;
  logic [3:0]  result_id_o;
  logic [4:0]  result_rd_o;
  logic [31:0] result_data_o;

  row_t   rows [NUM_ROWS];
  int     row_count = 0;
  int     errors = 0;
  int     checks = 0;
  integer seed = 32'h57f5;

  // Model of the vector CSR state
  logic [31:0] m_vl;
  logic [31:0] m_vstart;
  logic [7:0]  m_vtype;
  logic        m_vill;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (5)
  ) tb_clock_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  vctrl_top #(
    .VLEN (VLEN)
  ) vctrl_top_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .issue_valid_i  (issue_valid_i),
    .issue_ready_o  (issue_ready_o),
    .issue_instr_i  (issue_instr_i),
    .issue_rs1_i    (issue_rs1_i),
    .issue_rs2_i    (issue_rs2_i),
    .issue_id_i     (issue_id_i),
    .issue_accept_o (issue_accept_o),
    .vec_valid_o    (vec_valid_o),
    .vec_ready_i    (vec_ready_i),
    .vec_instr_o    (vec_instr_o),
    .vec_vl_o       (vec_vl_o),
    .vec_vtype_o    (vec_vtype_o),
    .vec_vstart_o   (vec_vstart_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_id_o    (result_id_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////

  function automatic logic [31:0] enc_vsetvli(input logic [7:0] zimm, input logic [4:0] rs1,
                                              input logic [4:0] rd);
    return {4'b0000, zimm, rs1, 3'd7, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_vsetvl(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [4:0] rd);
    return {1'b1, 6'd0, rs2, rs1, 3'd7, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_csr(input logic [11:0] csr, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
    return {csr, rs1, f3, rd, 7'h73};
  endfunction

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic add_row(input string name, input logic [31:0] instr, input logic [31:0] rs1,
                         input logic [31:0] rs2, input logic accept, input logic to_vec,
                         input logic [31:0] data, input logic stall);
    row_t r;
    r.name   = name;
    r.instr  = instr;
    r.rs1    = rs1;
    r.rs2    = rs2;
    r.id     = 4'(row_count);
    r.accept = accept;
    r.to_vec = to_vec;
    r.data   = data;
    r.stall  = stall;
    rows[row_count] = r;
    row_count++;
  endtask

  // Columns: name, instr, rs1, rs2, accept, vector port, result data, random stalls
  task automatic load_table();
    add_row("reset_vec_reject", VADD_A, 0, 0, 0, 0, 0, 0);
    add_row("reset_vtype_read", enc_csr(CSR_VTYPE, 0, 3'd2, 5), 0, 0, 1, 0, 32'h8000_0000, 0);
    add_row("vsetvli_avl100", enc_vsetvli(8'h11, 2, 1), 100, 0, 1, 0, 8, 0);
    add_row("vsetvli_avl3", enc_vsetvli(8'h11, 2, 1), 3, 0, 1, 0, 3, 0);
    add_row("vsetvli_vlmax", enc_vsetvli(8'h0f, 0, 1), 0, 0, 1, 0, 4, 0);
    add_row("vsetvli_sew64", enc_vsetvli(8'h19, 2, 1), 10, 0, 1, 0, 0, 0);
    add_row("vtype_read_ill", enc_csr(CSR_VTYPE, 0, 3'd2, 5), 0, 0, 1, 0, 32'h8000_0000, 0);
    add_row("vsetvl_same", enc_vsetvl(3, 2, 1), 100, 32'h11, 1, 0, 8, 0);
    add_row("vtype_read_cfg", enc_csr(CSR_VTYPE, 0, 3'd2, 5), 0, 0, 1, 0, 32'h11, 0);
    add_row("vstart_csrrw", enc_csr(CSR_VSTART, 6, 3'd1, 4), 5, 0, 1, 0, 0, 0);
    add_row("vstart_csrrs", enc_csr(CSR_VSTART, 6, 3'd2, 4), 32'h0a, 0, 1, 0, 5, 0);
    add_row("vstart_csrrc", enc_csr(CSR_VSTART, 6, 3'd3, 4), 3, 0, 1, 0, 32'h0f, 0);
    add_row("vlenb_read", enc_csr(CSR_VLENB, 0, 3'd2, 7), 0, 0, 1, 0, VLENB, 0);
    add_row("vl_write_reject", enc_csr(CSR_VL, 6, 3'd1, 0), 9, 0, 0, 0, 0, 0);
    add_row("vl_read", enc_csr(CSR_VL, 0, 3'd2, 8), 0, 0, 1, 0, 8, 0);
    add_row("vec_dispatch", VADD_A, 0, 0, 1, 1, 0, 0);
    add_row("vstart_after_vec", enc_csr(CSR_VSTART, 0, 3'd2, 9), 0, 0, 1, 0, 0, 0);
    add_row("vtype_write_reject", enc_csr(CSR_VTYPE, 6, 3'd2, 1), 1, 0, 0, 0, 0, 0);
    // Random ready stalls on both ports from here
    add_row("bp_vsetvli_e8m4", enc_vsetvli(8'h02, 2, 1), 50, 0, 1, 0, 50, 1);
    add_row("bp_vec_a", VADD_A, 0, 0, 1, 1, 0, 1);
    add_row("bp_vstart_write", enc_csr(CSR_VSTART, 6, 3'd1, 4), 7, 0, 1, 0, 0, 1);
    add_row("bp_vec_b", VADD_B, 0, 0, 1, 1, 0, 1);
    add_row("bp_vstart_read", enc_csr(CSR_VSTART, 0, 3'd2, 9), 0, 0, 1, 0, 0, 1);
    add_row("bp_vsetvli_lmul_res", enc_vsetvli(8'h04, 0, 1), 0, 0, 1, 0, 0, 1);
    add_row("bp_vec_reject", VADD_B, 0, 0, 0, 0, 0, 1);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] ref_vlmax(input logic [7:0] vt);
    logic [31:0] per_reg;
    per_reg = VLENB >> vt[5:3];
    case (vt[2:0])
      3'd0:    return per_reg;
      3'd1:    return per_reg * 2;
      3'd2:    return per_reg * 4;
      3'd3:    return per_reg * 8;
      3'd6:    return per_reg / 4;
      3'd7:    return per_reg / 2;
      default: return 0;
    endcase
  endfunction

  task automatic model_update(input row_t r);
    logic [7:0]  vt;
    logic [31:0] vlmax;
    logic [2:0]  f3;
    f3 = r.instr[14:12];
    if (r.instr[6:0] == 7'h57 && f3 == 3'd7) begin
      vt = r.instr[31] ? r.rs2[7:0] : r.instr[27:20];
      if (vt[5:3] > 3'd2 || vt[2:0] == 3'd4 || vt[2:0] == 3'd5) begin
        m_vill  = 1'b1;
        m_vtype = 8'd0;
        m_vl    = 0;
      end else begin
        vlmax   = ref_vlmax(vt);
        m_vill  = 1'b0;
        m_vtype = vt;
        if (r.instr[19:15] == 5'd0 && r.instr[11:7] != 5'd0) begin
          m_vl = vlmax;
        end else begin
          m_vl = (r.rs1 < vlmax) ? r.rs1 : vlmax;
        end
      end
    end else if (r.instr[6:0] == 7'h57) begin
      m_vstart = 0;
    end else if (r.instr[31:20] == CSR_VSTART) begin
      case (f3)
        3'd1:    m_vstart = r.rs1 & 32'hffff;
        3'd2:    m_vstart = (m_vstart | r.rs1) & 32'hffff;
        default: m_vstart = m_vstart & ~r.rs1;
      endcase
    end
  endtask

  //////////////////////////////////////////////////
  // Checks and drivers
  //////////////////////////////////////////////////

  task automatic check_value(input string test, input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("error %s: %s expected 0x%08h, actual 0x%08h", test, what, expected, actual);
    end
  endtask

  // Waits for the output handshake, then checks the port is empty again
  task automatic wait_output(input row_t r);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (r.stall) begin
        vec_ready_i    <= ($random(seed) & 3) != 0;
        result_ready_i <= ($random(seed) & 3) != 0;
      end else begin
        vec_ready_i    <= 1'b1;
        result_ready_i <= 1'b1;
      end
      @(negedge clk);
      done = (vec_valid_o && vec_ready_i) || (result_valid_o && result_ready_i);
    end
    check_value(r.name, "vector port", 32'(r.to_vec), 32'(vec_valid_o));
    if (r.to_vec) begin
      check_value(r.name, "vec_instr", r.instr, vec_instr_o);
      check_value(r.name, "vec_vl", m_vl, {16'd0, vec_vl_o});
      check_value(r.name, "vec_vtype", {23'd0, m_vill, m_vtype}, {23'd0, vec_vtype_o});
      check_value(r.name, "vec_vstart", m_vstart, {16'd0, vec_vstart_o});
    end else begin
      check_value(r.name, "result_data", r.data, result_data_o);
      check_value(r.name, "result_id", {28'd0, r.id}, {28'd0, result_id_o});
      check_value(r.name, "result_rd", {27'd0, r.instr[11:7]}, {27'd0, result_rd_o});
    end
    @(posedge clk);
    @(negedge clk);
    checks++;
    assert (!vec_valid_o && !result_valid_o) else begin
      errors++;
      $display("%s: a second output followed the handshake", r.name);
    end
  endtask

  task automatic expect_silence(input string test);
    repeat (3) begin
      @(negedge clk);
      checks++;
      assert (!vec_valid_o && !result_valid_o) else begin
        errors++;
        $display("%s: a rejected word produced an output", test);
      end
    end
  endtask

  task automatic run_row(input row_t r);
    @(posedge clk);
    issue_valid_i  <= 1'b1;
    issue_instr_i  <= r.instr;
    issue_rs1_i    <= r.rs1;
    issue_rs2_i    <= r.rs2;
    issue_id_i     <= r.id;
    vec_ready_i    <= 1'b0;
    result_ready_i <= 1'b0;
    @(negedge clk);
    // Nothing is in flight between rows
    check_value(r.name, "issue_ready", 32'd1, 32'(issue_ready_o));
    while (!issue_ready_o) begin
      @(negedge clk);
    end
    check_value(r.name, "accept", 32'(r.accept), 32'(issue_accept_o));
    // Transfer edge
    @(posedge clk);
    issue_valid_i <= 1'b0;
    if (r.accept) begin
      wait_output(r);
      model_update(r);
    end else begin
      expect_silence(r.name);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin : main
    int i;
    issue_valid_i  = 1'b0;
    issue_instr_i  = '0;
    issue_rs1_i    = '0;
    issue_rs2_i    = '0;
    issue_id_i     = '0;
    vec_ready_i    = 1'b0;
    result_ready_i = 1'b0;
    m_vl           = 0;
    m_vstart       = 0;
    m_vtype        = 8'd0;
    m_vill         = 1'b1;
    load_table();
    wait (rst_n == 1'b1);
    for (i = 0; i < row_count; i++) begin
      run_row(rows[i]);
    end
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(MAX_CYCLES * CLK_PERIOD);
    $display("Timeout: the table did not finish within %0d cycles", MAX_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
